// File: source/icache_pkg.sv
package icache_pkg;

    // geometry
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 6;
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;  // 20
    localparam int SETS     = 1 << INDEX_W;
    localparam int LINE_W   = 8 << OFFSET_W;            // 512 bit line
    localparam int FETCH_W  = 64;                       // two instructions per fetch

    // burst length codes, beats minus one
    localparam logic [7:0] RLEN_CACHED   = 8'd15;
    localparam logic [7:0] RLEN_UNCACHED = 8'd1;

    localparam logic [1:0] CACOP_STORE_TAG = 2'd0;
    localparam logic [1:0] CACOP_INDEX_INV = 2'd1;
    localparam logic [1:0] CACOP_HIT_INV   = 2'd2;

    // same address word, read as a fetch or as a cache operation
    typedef union packed {
        struct packed {
            logic [TAG_W-1:0]      tag;
            logic [INDEX_W-1:0]    index;
            logic [2:0]            dw;        // doubleword within the line
            logic [OFFSET_W-4:0]   byte_off;
        } f;
        struct packed {
            logic [TAG_W-1:0]      upper;
            logic [INDEX_W-1:0]    index;
            logic [OFFSET_W-2:0]   unused;
            logic                  way;       // way to clear
        } c;
    } icache_addr_u;

endpackage

// File: source/icache_way_ram.sv
`timescale 1ns/1ps

module icache_way_ram #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 6
) (
    input  logic              clk,
    input  logic              i_rd_en,
    input  logic [ADDR_W-1:0] i_rd_addr,
    input  logic              i_wr_en,
    input  logic [ADDR_W-1:0] i_wr_addr,
    input  logic [DATA_W-1:0] i_wr_data,
    output logic [DATA_W-1:0] o_rd_data
);
    logic [DATA_W-1:0] mem [1 << ADDR_W];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];  // registered read, old data on collision
        end
    end

endmodule

// File: source/icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store import icache_pkg::*; #(
    parameter int TAG_W   = 20,
    parameter int INDEX_W = 6
) (
    input  logic         clk,
    input  logic         rstn,
    input  logic         i_rd_en,
    input  icache_addr_u i_rd_addr,      // index read at acceptance
    input  icache_addr_u i_lookup_addr,  // latched request
    input  logic [1:0]   i_wr_way,
    input  logic         i_clear,
    output logic [1:0]   o_hit,
    output logic [1:0]   o_valid
);
    localparam int NSETS = 1 << INDEX_W;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [TAG_W-1:0] tag_rd;
        logic [NSETS-1:0] valid_q;

        // tag RAM only written on refill, a clear just drops valid
        icache_way_ram #(
            .DATA_W (TAG_W),
            .ADDR_W (INDEX_W)
        ) u_tag_ram (
            .clk       (clk),
            .i_rd_en   (i_rd_en),
            .i_rd_addr (i_rd_addr.f.index),
            .i_wr_en   (i_wr_way[w] & ~i_clear),
            .i_wr_addr (i_lookup_addr.f.index),
            .i_wr_data (i_lookup_addr.f.tag),
            .o_rd_data (tag_rd)
        );

        always_ff @(posedge clk) begin
            if (!rstn) begin
                valid_q <= '0;
            end else if (i_wr_way[w]) begin
                valid_q[i_lookup_addr.f.index] <= ~i_clear;
            end
        end

        assign o_valid[w] = valid_q[i_lookup_addr.f.index];
        assign o_hit[w]   = o_valid[w] & (tag_rd == i_lookup_addr.f.tag);
    end

endmodule

// File: source/icache_lru.sv
`timescale 1ns/1ps

module icache_lru import icache_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  icache_addr_u i_addr,
    input  logic         i_touch,
    input  logic         i_touch_way,
    input  logic         i_cacop_en,
    input  logic [1:0]   i_cacop_code,
    input  logic [1:0]   i_hit,
    output logic [1:0]   o_way_sel
);
    logic [SETS-1:0] lru_q;  // 1 means way 1 is the older one

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (i_touch) begin
            lru_q[i_addr.f.index] <= ~i_touch_way;  // other way becomes victim
        end
    end

    always_comb begin
        if (i_cacop_en) begin
            case (i_cacop_code)
                CACOP_STORE_TAG, CACOP_INDEX_INV: o_way_sel = i_addr.c.way ? 2'b10 : 2'b01;
                CACOP_HIT_INV:                    o_way_sel = i_hit;
                default:                          o_way_sel = 2'b00;  // unsupported op
            endcase
        end else begin
            o_way_sel = lru_q[i_addr.f.index] ? 2'b10 : 2'b01;
        end
    end

endmodule

// File: source/icache_data_path.sv
`timescale 1ns/1ps

module icache_data_path import icache_pkg::*; #(
    parameter int LINE_W  = 512,
    parameter int INDEX_W = 6
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_rd_en,
    input  icache_addr_u       i_rd_addr,
    input  icache_addr_u       i_lookup_addr,
    input  logic [1:0]         i_wr_way,
    input  logic [1:0]         i_hit,
    input  logic               i_mem_accept,
    input  logic [LINE_W-1:0]  i_mem_rdata,
    input  logic               i_from_ret,
    input  logic               i_uncached,
    output logic [FETCH_W-1:0] o_resp_data
);
    logic [LINE_W-1:0] ret_q;
    logic [LINE_W-1:0] line_rd [2];
    logic [LINE_W-1:0] line_sel;

    // return buffer, holds the line until REFILL writes it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ret_q <= '0;
        end else if (i_mem_accept) begin
            ret_q <= i_mem_rdata;
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_way_ram #(
            .DATA_W (LINE_W),
            .ADDR_W (INDEX_W)
        ) u_data_ram (
            .clk       (clk),
            .i_rd_en   (i_rd_en),
            .i_rd_addr (i_rd_addr.f.index),
            .i_wr_en   (i_wr_way[w] & i_from_ret),
            .i_wr_addr (i_lookup_addr.f.index),
            .i_wr_data (ret_q),
            .o_rd_data (line_rd[w])
        );
    end

    assign line_sel = i_from_ret ? ret_q : (i_hit[1] ? line_rd[1] : line_rd[0]);

    // uncached doubleword arrives in the top of the bus
    assign o_resp_data = i_uncached ? ret_q[LINE_W-1 -: FETCH_W]
                                    : line_sel[i_lookup_addr.f.dw * FETCH_W +: FETCH_W];

endmodule

// File: source/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         i_req_valid,
    input  icache_addr_u i_req_addr,
    input  logic         i_uncached,
    input  logic         i_cacop_en,
    input  logic [1:0]   i_cacop_code,
    input  logic         i_flush,
    input  logic [1:0]   i_hit,
    input  logic [1:0]   i_way_sel,
    input  logic         i_mem_rready,
    output logic         o_req_ready,
    output logic         o_rd_en,
    output icache_addr_u o_lookup_addr,
    output logic         o_uncached_q,
    output logic         o_cacop_en_q,
    output logic [1:0]   o_cacop_code_q,
    output logic [1:0]   o_wr_way,
    output logic         o_clear,
    output logic         o_touch,
    output logic         o_touch_way,
    output logic         o_mem_accept,
    output logic         o_from_ret,
    output logic         o_mem_rvalid,
    output logic [31:0]  o_mem_raddr,
    output logic [7:0]   o_mem_rlen,
    output logic         o_resp_valid,
    output icache_addr_u o_resp_pc,
    output logic         o_resp_adef,
    output logic         o_cacop_done
);
    localparam logic [2:0] IDLE   = 3'd0;
    localparam logic [2:0] LOOKUP = 3'd1;
    localparam logic [2:0] MISS   = 3'd2;
    localparam logic [2:0] REFILL = 3'd3;
    localparam logic [2:0] CACOP  = 3'd4;

    logic [2:0] state_q;
    logic [2:0] state_d;
    logic       accept;
    logic       misaligned;
    logic       lookup_hit;
    logic       lookup_done;  // answered in LOOKUP, no memory read
    logic       dropped_q;    // refill still runs, response is flushed

    assign accept      = i_req_valid & o_req_ready;
    assign misaligned  = o_lookup_addr.f.byte_off[1:0] != 2'b00;
    assign lookup_hit  = (|i_hit) & ~o_uncached_q & ~misaligned;
    assign lookup_done = misaligned | lookup_hit;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_lookup_addr  <= '0;
            o_uncached_q   <= 1'b0;
            o_cacop_en_q   <= 1'b0;
            o_cacop_code_q <= 2'b00;
        end else if (accept) begin
            o_lookup_addr  <= i_req_addr;
            o_uncached_q   <= i_uncached;
            o_cacop_en_q   <= i_cacop_en;
            o_cacop_code_q <= i_cacop_code;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q   <= IDLE;
            dropped_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == MISS && i_flush) begin
                dropped_q <= 1'b1;
            end else if (state_q == REFILL) begin
                dropped_q <= 1'b0;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        if (accept) begin
            state_d = i_cacop_en ? CACOP : LOOKUP;
        end else begin
            case (state_q)
                LOOKUP: begin
                    if (i_flush || lookup_done) begin
                        state_d = IDLE;
                    end else begin
                        state_d = i_mem_rready ? REFILL : MISS;
                    end
                end
                MISS: begin
                    if (i_mem_rready) begin
                        state_d = REFILL;
                    end
                end
                REFILL, CACOP: state_d = IDLE;
                default:       state_d = IDLE;
            endcase
        end
    end

    // ready stays up in LOOKUP on a hit so fetches pipeline
    assign o_req_ready = (state_q == IDLE) ||
                         (state_q == LOOKUP && (i_flush || lookup_done));
    assign o_rd_en     = accept;

    assign o_mem_rvalid = (state_q == LOOKUP && !lookup_done && !i_flush) || (state_q == MISS);
    assign o_mem_accept = o_mem_rvalid & i_mem_rready;
    assign o_mem_raddr  = o_uncached_q ? {o_lookup_addr[31:3], 3'b000}
                                       : {o_lookup_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign o_mem_rlen   = o_uncached_q ? RLEN_UNCACHED : RLEN_CACHED;

    assign o_from_ret = state_q == REFILL;
    assign o_clear    = state_q == CACOP;
    assign o_wr_way   = ((state_q == REFILL && !o_uncached_q) || state_q == CACOP) ? i_way_sel
                                                                                    : 2'b00;

    assign o_touch     = (state_q == LOOKUP && lookup_hit && !i_flush) ||
                         (state_q == REFILL && !o_uncached_q);
    assign o_touch_way = (state_q == REFILL) ? i_way_sel[1] : i_hit[1];

    assign o_resp_valid = (state_q == LOOKUP && lookup_done && !i_flush) ||
                          (state_q == REFILL && !dropped_q && !i_flush);
    assign o_resp_pc    = o_lookup_addr;
    assign o_resp_adef  = (state_q == LOOKUP) && misaligned;
    assign o_cacop_done = state_q == CACOP;

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    // pipeline side
    input  logic               i_req_valid,
    output logic               o_req_ready,
    input  logic [31:0]        i_req_addr,
    input  logic               i_uncached,
    input  logic               i_cacop_en,
    input  logic [1:0]         i_cacop_code,
    input  logic               i_flush,
    output logic               o_resp_valid,
    output logic [FETCH_W-1:0] o_resp_data,
    output logic [31:0]        o_resp_pc,
    output logic               o_resp_adef,
    output logic               o_cacop_done,
    // memory side
    output logic               o_mem_rvalid,
    input  logic               i_mem_rready,
    output logic [31:0]        o_mem_raddr,
    output logic [7:0]         o_mem_rlen,
    input  logic [LINE_W-1:0]  i_mem_rdata
);
    icache_addr_u lookup_addr;
    logic         rd_en;
    logic         uncached_q;
    logic         cacop_en_q;
    logic [1:0]   cacop_code_q;
    logic [1:0]   hit;
    logic [1:0]   way_sel;
    logic [1:0]   wr_way;
    logic         clear;
    logic         touch;
    logic         touch_way;
    logic         mem_accept;
    logic         from_ret;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .i_req_valid    (i_req_valid),
        .i_req_addr     (i_req_addr),
        .i_uncached     (i_uncached),
        .i_cacop_en     (i_cacop_en),
        .i_cacop_code   (i_cacop_code),
        .i_flush        (i_flush),
        .i_hit          (hit),
        .i_way_sel      (way_sel),
        .i_mem_rready   (i_mem_rready),
        .o_req_ready    (o_req_ready),
        .o_rd_en        (rd_en),
        .o_lookup_addr  (lookup_addr),
        .o_uncached_q   (uncached_q),
        .o_cacop_en_q   (cacop_en_q),
        .o_cacop_code_q (cacop_code_q),
        .o_wr_way       (wr_way),
        .o_clear        (clear),
        .o_touch        (touch),
        .o_touch_way    (touch_way),
        .o_mem_accept   (mem_accept),
        .o_from_ret     (from_ret),
        .o_mem_rvalid   (o_mem_rvalid),
        .o_mem_raddr    (o_mem_raddr),
        .o_mem_rlen     (o_mem_rlen),
        .o_resp_valid   (o_resp_valid),
        .o_resp_pc      (o_resp_pc),
        .o_resp_adef    (o_resp_adef),
        .o_cacop_done   (o_cacop_done)
    );

    icache_tag_store #(
        .TAG_W   (TAG_W),
        .INDEX_W (INDEX_W)
    ) u_tag (
        .clk           (clk),
        .rstn          (rstn),
        .i_rd_en       (rd_en),
        .i_rd_addr     (i_req_addr),
        .i_lookup_addr (lookup_addr),
        .i_wr_way      (wr_way),
        .i_clear       (clear),
        .o_hit         (hit),
        .o_valid       ()
    );

    icache_lru u_lru (
        .clk          (clk),
        .rstn         (rstn),
        .i_addr       (lookup_addr),
        .i_touch      (touch),
        .i_touch_way  (touch_way),
        .i_cacop_en   (cacop_en_q),
        .i_cacop_code (cacop_code_q),
        .i_hit        (hit),
        .o_way_sel    (way_sel)
    );

    icache_data_path #(
        .LINE_W  (LINE_W),
        .INDEX_W (INDEX_W)
    ) u_data (
        .clk           (clk),
        .rstn          (rstn),
        .i_rd_en       (rd_en),
        .i_rd_addr     (i_req_addr),
        .i_lookup_addr (lookup_addr),
        .i_wr_way      (wr_way),
        .i_hit         (hit),
        .i_mem_accept  (mem_accept),
        .i_mem_rdata   (i_mem_rdata),
        .i_from_ret    (from_ret),
        .i_uncached    (uncached_q),
        .o_resp_data   (o_resp_data)
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rstn
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rstn = 1'b1;
    end

endmodule

// File: tests/icache_monitor.sv
`timescale 1ns/1ps

module icache_monitor import icache_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_req_valid,
    input  logic               i_req_ready,
    input  logic [31:0]        i_req_addr,
    input  logic               i_uncached,
    input  logic               i_cacop_en,
    input  logic [1:0]         i_cacop_code,
    input  logic               i_flush,
    input  logic               i_resp_valid,
    input  logic [FETCH_W-1:0] i_resp_data,
    input  logic [31:0]        i_resp_pc,
    input  logic               i_resp_adef,
    input  logic               i_cacop_done,
    input  logic               i_mem_rvalid,
    input  logic               i_mem_rready,
    input  logic [31:0]        i_mem_raddr,
    input  logic [7:0]         i_mem_rlen,
    input  logic [8*16-1:0]    i_test_name,
    output logic               o_idle,
    output int                 o_errors
);
    logic [TAG_W-1:0] m_tag [SETS][2];
    logic             m_valid [SETS][2];
    logic             m_lru [SETS];  // way replaced next

    int          stage = 0;  // 0 idle, 1 lookup, 2 memory, 3 refill
    int          errors = 0;
    logic [31:0] p_addr;
    logic        p_unc;
    logic        p_cop;
    logic        p_drop;
    logic [1:0]  p_code;

    assign o_idle   = stage == 0;
    assign o_errors = errors;

    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        return (byte_addr >> 2) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [63:0] expect_dw(input logic [31:0] a);
        return {mem_word({a[31:3], 3'b100}), mem_word({a[31:3], 3'b000})};
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %0s %0s: expected %h actual %h",
                     i_test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input logic adef);
        check_val("resp_valid", 1, i_resp_valid);
        check_val("resp_adef", adef, i_resp_adef);
        check_val("resp_pc", p_addr, i_resp_pc);
        if (!adef) begin
            check_val("resp_data", expect_dw(p_addr), i_resp_data);
        end
    endtask

    task automatic watch_memory();
        logic [31:0] exp_addr;
        exp_addr = p_unc ? {p_addr[31:3], 3'b000} : {p_addr[31:6], 6'b0};
        check_val("mem_rvalid", 1, i_mem_rvalid);
        check_val("mem_raddr", exp_addr, i_mem_raddr);
        check_val("mem_rlen", p_unc ? RLEN_UNCACHED : RLEN_CACHED, i_mem_rlen);
        check_val("resp_valid", 0, i_resp_valid);
        check_val("req_ready", 0, i_req_ready);  // miss holds off new requests
        if (i_flush) begin
            p_drop = 1'b1;  // refill runs on, answer is lost
        end
        stage = i_mem_rready ? 3 : 2;
    endtask

    task automatic finish_lookup();
        logic [5:0] set;
        int         hw;
        int         w;
        set = p_addr[11:6];
        hw  = -1;
        for (w = 0; w < 2; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == p_addr[31:12]) hw = w;
        end
        stage = 0;
        if (p_cop) begin
            check_val("cacop_done", 1, i_cacop_done);
            check_val("req_ready", 0, i_req_ready);
            check_val("resp_valid", 0, i_resp_valid);
            case (p_code)
                CACOP_STORE_TAG, CACOP_INDEX_INV: m_valid[set][p_addr[0]] = 1'b0;
                CACOP_HIT_INV: if (hw >= 0) m_valid[set][hw] = 1'b0;
                default: ;
            endcase
        end else if (i_flush) begin
            check_val("resp_valid", 0, i_resp_valid);
            check_val("mem_rvalid", 0, i_mem_rvalid);
        end else if (p_addr[1:0] != 2'b00) begin
            check_resp(1'b1);
            check_val("mem_rvalid", 0, i_mem_rvalid);
        end else if (!p_unc && hw >= 0) begin
            check_resp(1'b0);
            check_val("mem_rvalid", 0, i_mem_rvalid);
            check_val("req_ready", 1, i_req_ready);
            m_lru[set] = (hw == 0);
        end else begin
            watch_memory();
        end
    endtask

    task automatic finish_refill();
        logic [5:0] set;
        logic       victim;
        set = p_addr[11:6];
        check_val("mem_rvalid", 0, i_mem_rvalid);
        if (p_drop || i_flush) begin
            check_val("resp_valid", 0, i_resp_valid);
        end else begin
            check_resp(1'b0);
        end
        if (!p_unc) begin
            victim = m_lru[set];
            m_tag[set][victim]   = p_addr[31:12];
            m_valid[set][victim] = 1'b1;
            m_lru[set]           = ~victim;
        end
        stage = 0;
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                m_valid[s][0] = 1'b0;
                m_valid[s][1] = 1'b0;
                m_lru[s]      = 1'b0;
            end
            stage = 0;
        end else begin
            case (stage)
                0: begin
                    check_val("req_ready", 1, i_req_ready);
                    if (i_resp_valid || i_mem_rvalid || i_cacop_done) begin
                        $display("%0s: output strobe with no request in flight", i_test_name);
                        errors++;
                    end
                end
                1:       finish_lookup();
                2:       watch_memory();
                default: finish_refill();
            endcase
            if (i_req_valid && i_req_ready) begin
                p_addr = i_req_addr;
                p_unc  = i_uncached;
                p_cop  = i_cacop_en;
                p_code = i_cacop_code;
                p_drop = 1'b0;
                stage  = 1;
            end
        end
    end

endmodule

// File: tests/icache_chk.sv
`timescale 1ns/1ps

module icache_chk (
    input logic        clk,
    input logic        rstn,
    input logic        i_mem_rvalid,
    input logic        i_mem_rready,
    input logic [31:0] i_mem_raddr,
    input logic [7:0]  i_mem_rlen,
    input logic        i_resp_valid,
    input logic        i_cacop_done
);
    int fail_count = 0;  // read by the testbench at the end

    // read request holds until memory takes it
    assert property (@(posedge clk) disable iff (!rstn)
        i_mem_rvalid && !i_mem_rready |=>
            i_mem_rvalid && $stable(i_mem_raddr) && $stable(i_mem_rlen))
    else begin
        fail_count++;
        $error("memory read request dropped or changed before rready");
    end

    assert property (@(posedge clk) disable iff (!rstn) !(i_resp_valid && i_cacop_done))
    else begin
        fail_count++;
        $error("fetch response and cache operation done in the same cycle");
    end

endmodule

bind icache_ctrl icache_chk u_chk (
    .clk          (clk),
    .rstn         (rstn),
    .i_mem_rvalid (o_mem_rvalid),
    .i_mem_rready (i_mem_rready),
    .i_mem_raddr  (o_mem_raddr),
    .i_mem_rlen   (o_mem_rlen),
    .i_resp_valid (o_resp_valid),
    .i_cacop_done (o_cacop_done)
);

// File: tests/icache_tb.sv
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();
    logic               clk;
    logic               rstn;
    logic               i_req_valid;
    logic               o_req_ready;
    logic [31:0]        i_req_addr;
    logic               i_uncached;
    logic               i_cacop_en;
    logic [1:0]         i_cacop_code;
    logic               i_flush;
    logic               o_resp_valid;
    logic [FETCH_W-1:0] o_resp_data;
    logic [31:0]        o_resp_pc;
    logic               o_resp_adef;
    logic               o_cacop_done;
    logic               o_mem_rvalid;
    logic               i_mem_rready;
    logic [31:0]        o_mem_raddr;
    logic [7:0]         o_mem_rlen;
    logic [LINE_W-1:0]  i_mem_rdata;

    logic [8*16-1:0]    test_name;
    logic               mon_idle;
    int                 mon_errors;
    integer             seed;
    int                 timeouts;
    int                 tests_run;
    int                 tests_failed;
    int                 fails_before;

    logic               mem_seen;
    logic               mem_busy;
    int                 mem_wait;
    logic [31:0]        mem_addr;
    logic [7:0]         mem_len;

    tb_clock u_clk (.o_clk(clk), .o_rstn(rstn));

    icache_top UUT (.*);

    icache_monitor u_mon (
        .clk (clk), .rstn (rstn),
        .i_req_valid (i_req_valid), .i_req_ready (o_req_ready), .i_req_addr (i_req_addr),
        .i_uncached (i_uncached), .i_cacop_en (i_cacop_en), .i_cacop_code (i_cacop_code),
        .i_flush (i_flush), .i_resp_valid (o_resp_valid), .i_resp_data (o_resp_data),
        .i_resp_pc (o_resp_pc), .i_resp_adef (o_resp_adef), .i_cacop_done (o_cacop_done),
        .i_mem_rvalid (o_mem_rvalid), .i_mem_rready (i_mem_rready),
        .i_mem_raddr (o_mem_raddr), .i_mem_rlen (o_mem_rlen),
        .i_test_name (test_name), .o_idle (mon_idle), .o_errors (mon_errors)
    );

    function automatic logic [31:0] word_at(input logic [31:0] byte_addr);
        return (byte_addr >> 2) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [LINE_W-1:0] build_line(input logic [31:0] a, input logic [7:0] len);
        logic [LINE_W-1:0] line;
        line = '0;
        if (len == RLEN_UNCACHED) begin
            line[LINE_W-1 -: 64] = {word_at(a + 32'd4), word_at(a)};  // top doubleword
        end else begin
            for (int i = 0; i < 16; i++) line[i*32 +: 32] = word_at(a + 32'(i * 4));
        end
        return line;
    endfunction

    // memory answers 0 to 5 cycles after it sees a request
    always @(posedge clk) begin
        mem_seen = o_mem_rvalid && !i_mem_rready;
        mem_addr = o_mem_raddr;
        mem_len  = o_mem_rlen;
        #1;
        i_mem_rready = 1'b0;
        if (!rstn || !mem_seen) begin
            mem_busy = 1'b0;
        end else begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = int'($unsigned($random(seed)) % 6);
            end
            if (mem_wait == 0) begin
                i_mem_rready = 1'b1;
                i_mem_rdata  = build_line(mem_addr, mem_len);
                mem_busy     = 1'b0;
            end else begin
                mem_wait--;
            end
        end
    end

    function automatic logic [31:0] make_addr(input logic [19:0] tag, input logic [5:0] set,
                                              input logic [2:0] dw);
        return {tag, set, dw, 3'b000};
    endfunction

    function automatic logic [31:0] random_addr();
        logic [19:0] tag;
        logic [5:0]  set;
        tag = 20'h00010 + 20'($unsigned($random(seed)) % 4);
        case ($unsigned($random(seed)) % 3)
            0:       set = 6'd3;
            1:       set = 6'd17;
            default: set = 6'd40;
        endcase
        return make_addr(tag, set, 3'($random(seed))) | ($random(seed) & 32'h4);
    endfunction

    task automatic issue(input logic [31:0] a, input logic unc, input logic cop,
                         input logic [1:0] code);
        int n;
        i_req_addr   = a;
        i_uncached   = unc;
        i_cacop_en   = cop;
        i_cacop_code = code;
        i_req_valid  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!o_req_ready) begin
            n++;
            if (n > 100) begin
                $display("%0s: request was never accepted", test_name);
                timeouts++;
                break;
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        i_req_valid = 1'b0;
        i_cacop_en  = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge clk);
        while (!mon_idle) begin
            n++;
            if (n > 100) begin
                $display("%0s: request did not complete within 100 cycles", test_name);
                timeouts++;
                break;
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // flush_at 1 flushes the lookup cycle, 2 the first miss cycle
    task automatic fetch(input logic [31:0] a, input logic unc, input int flush_at);
        int n;
        issue(a, unc, 1'b0, 2'b00);
        if (flush_at == 1) begin
            i_flush = 1'b1;
            @(posedge clk);
            #1;
            i_flush = 1'b0;
        end else if (flush_at == 2) begin
            n = 0;
            @(negedge clk);
            while (!o_mem_rvalid) begin
                n++;
                if (n > 20) begin
                    $display("%0s: no memory read appeared for the flushed miss", test_name);
                    timeouts++;
                    break;
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            i_flush = 1'b1;
            @(posedge clk);
            #1;
            i_flush = 1'b0;
        end
        wait_done();
    endtask

    task automatic cacop(input logic [31:0] a, input logic [1:0] code);
        issue(a, 1'b0, 1'b1, code);
        wait_done();
    endtask

    task automatic start_test(input logic [8*16-1:0] name);
        test_name    = name;
        fails_before = mon_errors + timeouts;
    endtask

    task automatic end_test();
        int fails;
        fails = mon_errors + timeouts - fails_before;
        tests_run++;
        if (fails == 0) begin
            $display("test %0s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %0s: failed with %0d errors", test_name, fails);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int          n;
        seed         = 32'h1a6f_f6c4;
        i_req_valid  = 1'b0;
        i_req_addr   = '0;
        i_uncached   = 1'b0;
        i_cacop_en   = 1'b0;
        i_cacop_code = 2'b00;
        i_flush      = 1'b0;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        mem_busy     = 1'b0;
        mem_wait     = 0;
        timeouts     = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        n = 0;
        while (!rstn && n < 20) begin
            n++;
            @(posedge clk);
        end
        @(posedge clk);
        #1;

        start_test("random_fetch");
        repeat (80) fetch(random_addr(), 1'b0, 0);
        end_test();

        start_test("replacement");
        a = make_addr(20'h00100, 6'd50, 3'd0);
        b = make_addr(20'h00101, 6'd50, 3'd4);
        c = make_addr(20'h00102, 6'd50, 3'd7);
        fetch(a, 1'b0, 0);
        fetch(b, 1'b0, 0);
        fetch(a, 1'b0, 0);
        fetch(c, 1'b0, 0);  // b is the older way
        fetch(a, 1'b0, 0);
        fetch(c, 1'b0, 0);
        fetch(b, 1'b0, 0);
        end_test();

        start_test("uncached");
        a = make_addr(20'h00c00, 6'd60, 3'd5);
        fetch(a, 1'b1, 0);
        fetch(a, 1'b1, 0);
        fetch(a, 1'b0, 0);
        fetch(a, 1'b1, 0);
        repeat (6) fetch(random_addr(), 1'b1, 0);
        end_test();

        start_test("misaligned");
        for (int k = 1; k < 4; k++) begin
            fetch(make_addr(20'h00100, 6'd50, 3'd2) | 32'(k), 1'b0, 0);
            fetch(random_addr() | 32'(k), 1'b1, 0);
        end
        end_test();

        start_test("cache_op");
        a = make_addr(20'h00200, 6'd20, 3'd1);
        b = make_addr(20'h00201, 6'd20, 3'd2);
        fetch(a, 1'b0, 0);
        fetch(b, 1'b0, 0);
        cacop({20'h0, 6'd20, 6'b000000}, CACOP_INDEX_INV);  // way 0
        fetch(a, 1'b0, 0);
        fetch(b, 1'b0, 0);
        cacop({20'h0, 6'd20, 6'b000001}, CACOP_STORE_TAG);  // way 1
        fetch(a, 1'b0, 0);
        fetch(b, 1'b0, 0);
        cacop(a, CACOP_HIT_INV);
        fetch(b, 1'b0, 0);
        fetch(a, 1'b0, 0);
        end_test();

        start_test("flush");
        a = make_addr(20'h00300, 6'd33, 3'd3);
        fetch(b, 1'b0, 1);
        fetch(a, 1'b0, 1);
        fetch(a, 1'b0, 2);
        fetch(a, 1'b0, 0);  // refill finished, so a hit
        fetch(make_addr(20'h00c01, 6'd61, 3'd6), 1'b1, 2);
        end_test();

        $display("tests %0d, failed %0d, check errors %0d, timeouts %0d, assertion errors %0d",
                 tests_run, tests_failed, mon_errors, timeouts, UUT.u_ctrl.u_chk.fail_count);
        if (tests_failed == 0 && mon_errors == 0 && timeouts == 0 &&
            UUT.u_ctrl.u_chk.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (20000) @(posedge clk);
        $display("simulation stopped by the watchdog after 20000 cycles");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: icache.f
source/icache_pkg.sv
source/icache_way_ram.sv
source/icache_tag_store.sv
source/icache_lru.sv
source/icache_data_path.sv
source/icache_ctrl.sv
source/icache_top.sv
tests/tb_clock.sv
tests/icache_monitor.sv
tests/icache_chk.sv
tests/icache_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := icache_tb
FILELIST  := icache.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "no pass line in log"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
